// File: Bender.yml
package:
  name: ahb_matrix

export_include_dirs:
  - hdl

sources:
  - hdl/ahb_pkg.sv
  - hdl/soc_map_pkg.sv
  - hdl/ahb_slave_if.sv
  - hdl/ahb_interconnect.sv
  - hdl/ahb_ram_slave.sv
  - hdl/ahb_gpio_slave.sv
  - hdl/ahb_timer_slave.sv
  - hdl/ahb_matrix.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_ahb_matrix.sv

// File: build.f
+incdir+hdl
hdl/ahb_pkg.sv
hdl/soc_map_pkg.sv
hdl/ahb_slave_if.sv
hdl/ahb_interconnect.sv
hdl/ahb_ram_slave.sv
hdl/ahb_gpio_slave.sv
hdl/ahb_timer_slave.sv
hdl/ahb_matrix.sv
verification/tb_clock_gen.sv
verification/tb_ahb_matrix.sv

// File: hdl/ahb_gpio_slave.sv
`timescale 1ns/1ns
`include "soc_consts.svh"

module ahb_gpio_slave (
    input  logic                         HCLK,
    input  logic                         rst_n,
    ahb_slave_if.slave                   bus,
    input  logic [`SOC_SWITCH_WIDTH-1:0] io_switches,
    input  logic [`SOC_BUTTON_WIDTH-1:0] io_buttons,
    output logic [`SOC_RED_WIDTH-1:0]    io_red_leds,
    output logic [`SOC_GREEN_WIDTH-1:0]  io_green_leds
);

    soc_map_pkg::gpio_reg_t reg_q;   // offset of the current data phase.
    logic accept;
    logic wr_pending;

    assign accept = bus.hsel && bus.hready &&
                    ((bus.htrans == ahb_pkg::trans_nonseq) || (bus.htrans == ahb_pkg::trans_seq));

    always_ff @(posedge HCLK or negedge rst_n) begin
        if (!rst_n) begin
            reg_q         <= soc_map_pkg::gpio_switches;
            wr_pending    <= 1'b0;
            io_red_leds   <= '0;
            io_green_leds <= '0;
        end else begin
            if (accept)
                reg_q <= soc_map_pkg::gpio_reg_t'(bus.haddr[3:2]);
            if (bus.hready)
                wr_pending <= accept && bus.hwrite;
            if (wr_pending && bus.hready) begin
                case (reg_q)   // switches and buttons are read only.
                    soc_map_pkg::gpio_red_leds:   io_red_leds   <= bus.hwdata[`SOC_RED_WIDTH-1:0];
                    soc_map_pkg::gpio_green_leds: io_green_leds <= bus.hwdata[`SOC_GREEN_WIDTH-1:0];
                    default: ;
                endcase
            end
        end
    end

    // inputs are sampled live during the data phase.
    always_comb begin
        bus.hrdata = 32'h0;
        case (reg_q)
            soc_map_pkg::gpio_switches:   bus.hrdata[`SOC_SWITCH_WIDTH-1:0] = io_switches;
            soc_map_pkg::gpio_buttons:    bus.hrdata[`SOC_BUTTON_WIDTH-1:0] = io_buttons;
            soc_map_pkg::gpio_red_leds:   bus.hrdata[`SOC_RED_WIDTH-1:0]    = io_red_leds;
            soc_map_pkg::gpio_green_leds: bus.hrdata[`SOC_GREEN_WIDTH-1:0]  = io_green_leds;
            default: ;
        endcase
    end

    assign bus.hreadyout = 1'b1;
    assign bus.hresp     = ahb_pkg::resp_okay;

endmodule

// File: hdl/ahb_interconnect.sv
`timescale 1ns/1ns
`include "soc_consts.svh"

module ahb_interconnect (
    input  logic             HCLK,
    input  logic             rst_n,
    input  logic [31:0]      haddr,
    input  ahb_pkg::htrans_t htrans,
    input  logic             hwrite,
    input  logic [31:0]      hwdata,
    output logic [31:0]      hrdata,
    output logic             hready,
    output ahb_pkg::hresp_t  hresp,
    ahb_slave_if.master      ram_bus,
    ahb_slave_if.master      gpio_bus,
    ahb_slave_if.master      timer_bus
);

    soc_map_pkg::slave_sel_t addr_sel;   // address phase.
    soc_map_pkg::slave_sel_t data_sel;   // data phase.
    logic trans_active;
    logic err_first;                     // default slave, hready low.
    logic err_second;                    // default slave, hready high.

    assign trans_active = (htrans == ahb_pkg::trans_nonseq) || (htrans == ahb_pkg::trans_seq);

    always_comb begin
        if (haddr[28] == `SOC_RAM_MATCH)
            addr_sel = soc_map_pkg::sel_ram;
        else if (haddr[28:22] == `SOC_GPIO_MATCH)
            addr_sel = soc_map_pkg::sel_gpio;
        else if (haddr[28:22] == `SOC_TIMER_MATCH)
            addr_sel = soc_map_pkg::sel_timer;
        else
            addr_sel = soc_map_pkg::sel_none;
    end

    assign ram_bus.hsel   = (addr_sel == soc_map_pkg::sel_ram);
    assign gpio_bus.hsel  = (addr_sel == soc_map_pkg::sel_gpio);
    assign timer_bus.hsel = (addr_sel == soc_map_pkg::sel_timer);

    // address and write data go to every slave unchanged.
    assign ram_bus.haddr    = haddr;
    assign ram_bus.htrans   = htrans;
    assign ram_bus.hwrite   = hwrite;
    assign ram_bus.hwdata   = hwdata;
    assign ram_bus.hready   = hready;
    assign gpio_bus.haddr   = haddr;
    assign gpio_bus.htrans  = htrans;
    assign gpio_bus.hwrite  = hwrite;
    assign gpio_bus.hwdata  = hwdata;
    assign gpio_bus.hready  = hready;
    assign timer_bus.haddr  = haddr;
    assign timer_bus.htrans = htrans;
    assign timer_bus.hwrite = hwrite;
    assign timer_bus.hwdata = hwdata;
    assign timer_bus.hready = hready;

    always_ff @(posedge HCLK or negedge rst_n) begin
        if (!rst_n) begin
            data_sel   <= soc_map_pkg::sel_ram;
            err_first  <= 1'b0;
            err_second <= 1'b0;
        end else if (err_first) begin
            err_first  <= 1'b0;
            err_second <= 1'b1;
        end else if (hready) begin
            data_sel   <= addr_sel;
            err_first  <= trans_active && (addr_sel == soc_map_pkg::sel_none);
            err_second <= 1'b0;
        end
    end

    always_comb begin
        case (data_sel)
            soc_map_pkg::sel_ram: begin
                hrdata = ram_bus.hrdata;
                hready = ram_bus.hreadyout;
                hresp  = ram_bus.hresp;
            end
            soc_map_pkg::sel_gpio: begin
                hrdata = gpio_bus.hrdata;
                hready = gpio_bus.hreadyout;
                hresp  = gpio_bus.hresp;
            end
            soc_map_pkg::sel_timer: begin
                hrdata = timer_bus.hrdata;
                hready = timer_bus.hreadyout;
                hresp  = timer_bus.hresp;
            end
            default: begin
                hrdata = 32'h0;
                hready = !err_first;
                hresp  = (err_first || err_second) ? ahb_pkg::resp_error : ahb_pkg::resp_okay;
            end
        endcase
    end

endmodule

// File: hdl/ahb_matrix.sv
`timescale 1ns/1ns
`include "soc_consts.svh"

module ahb_matrix (
    input  logic                         HCLK,
    input  logic                         rst_n,
    input  logic [31:0]                  haddr,
    input  ahb_pkg::htrans_t             htrans,
    input  logic                         hwrite,
    input  logic [31:0]                  hwdata,
    output logic [31:0]                  hrdata,
    output logic                         hready,
    output ahb_pkg::hresp_t              hresp,
    input  logic [`SOC_SWITCH_WIDTH-1:0] io_switches,
    input  logic [`SOC_BUTTON_WIDTH-1:0] io_buttons,
    output logic [`SOC_RED_WIDTH-1:0]    io_red_leds,
    output logic [`SOC_GREEN_WIDTH-1:0]  io_green_leds,
    output logic                         timer_irq
);

    ahb_slave_if ram_bus ();
    ahb_slave_if gpio_bus ();
    ahb_slave_if timer_bus ();

    ahb_interconnect u_interconnect (
        .HCLK      (HCLK),
        .rst_n     (rst_n),
        .haddr     (haddr),
        .htrans    (htrans),
        .hwrite    (hwrite),
        .hwdata    (hwdata),
        .hrdata    (hrdata),
        .hready    (hready),
        .hresp     (hresp),
        .ram_bus   (ram_bus.master),
        .gpio_bus  (gpio_bus.master),
        .timer_bus (timer_bus.master)
    );

    ahb_ram_slave #(
        .ADDR_WIDTH (`SOC_RAM_ADDR_WIDTH)
    ) u_ram (
        .HCLK  (HCLK),
        .rst_n (rst_n),
        .bus   (ram_bus.slave)
    );

    ahb_gpio_slave u_gpio (
        .HCLK          (HCLK),
        .rst_n         (rst_n),
        .bus           (gpio_bus.slave),
        .io_switches   (io_switches),
        .io_buttons    (io_buttons),
        .io_red_leds   (io_red_leds),
        .io_green_leds (io_green_leds)
    );

    ahb_timer_slave u_timer (
        .HCLK      (HCLK),
        .rst_n     (rst_n),
        .bus       (timer_bus.slave),
        .timer_irq (timer_irq)
    );

endmodule

// File: hdl/ahb_pkg.sv
package ahb_pkg;

    // transfer type on htrans.
    typedef enum logic [1:0] {
        trans_idle   = 2'b00,
        trans_busy   = 2'b01,
        trans_nonseq = 2'b10,
        trans_seq    = 2'b11
    } htrans_t;

    typedef enum logic {
        resp_okay  = 1'b0,
        resp_error = 1'b1
    } hresp_t;

    // RAM read sequencing.
    typedef enum logic [1:0] {
        ram_idle,
        ram_read_wait,
        ram_read_done
    } ram_state_t;

endpackage

// File: hdl/ahb_ram_slave.sv
`timescale 1ns/1ns
`include "soc_consts.svh"

module ahb_ram_slave #(
    parameter int ADDR_WIDTH = `SOC_RAM_ADDR_WIDTH
) (
    input  logic       HCLK,
    input  logic       rst_n,
    ahb_slave_if.slave bus
);

    logic [31:0] mem [0:(2**ADDR_WIDTH)-1];

    ahb_pkg::ram_state_t   state;
    ahb_pkg::ram_state_t   state_next;
    logic                  accept;
    logic                  wr_pending;   // write data phase in progress.
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [31:0]           rdata_q;

    assign accept = bus.hsel && bus.hready &&
                    ((bus.htrans == ahb_pkg::trans_nonseq) || (bus.htrans == ahb_pkg::trans_seq));

    always_comb begin
        state_next = state;
        case (state)
            ahb_pkg::ram_idle, ahb_pkg::ram_read_done: begin
                if (accept && !bus.hwrite)
                    state_next = ahb_pkg::ram_read_wait;
                else
                    state_next = ahb_pkg::ram_idle;
            end
            ahb_pkg::ram_read_wait: state_next = ahb_pkg::ram_read_done;
            default: state_next = ahb_pkg::ram_idle;
        endcase
    end

    always_ff @(posedge HCLK or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ahb_pkg::ram_idle;
            wr_pending <= 1'b0;
        end else begin
            state <= state_next;
            if (bus.hready)
                wr_pending <= accept && bus.hwrite;
        end
    end

    // a write commits on the edge that accepts a following read, and the
    // array is only read one edge later, in read_wait. so the read sees
    // the new word without a bypass path.
    always_ff @(posedge HCLK) begin
        if (accept)
            addr_q <= bus.haddr[ADDR_WIDTH+1:2];
        if (wr_pending && bus.hready)
            mem[addr_q] <= bus.hwdata;
        if (state == ahb_pkg::ram_read_wait)
            rdata_q <= mem[addr_q];
    end

    assign bus.hrdata    = rdata_q;
    assign bus.hreadyout = (state != ahb_pkg::ram_read_wait);
    assign bus.hresp     = ahb_pkg::resp_okay;

endmodule

// File: hdl/ahb_slave_if.sv
`timescale 1ns/1ns

interface ahb_slave_if;

    logic             hsel;
    logic [31:0]      haddr;
    ahb_pkg::htrans_t htrans;
    logic             hwrite;
    logic [31:0]      hwdata;
    logic             hready;      // bus ready, fed back to every slave.
    logic [31:0]      hrdata;
    logic             hreadyout;
    ahb_pkg::hresp_t  hresp;

    modport master (
        output hsel, haddr, htrans, hwrite, hwdata, hready,
        input  hrdata, hreadyout, hresp
    );

    modport slave (
        input  hsel, haddr, htrans, hwrite, hwdata, hready,
        output hrdata, hreadyout, hresp
    );

endinterface

// File: hdl/ahb_timer_slave.sv
`timescale 1ns/1ns

module ahb_timer_slave (
    input  logic       HCLK,
    input  logic       rst_n,
    ahb_slave_if.slave bus,
    output logic       timer_irq
);

    soc_map_pkg::timer_reg_t reg_q;
    logic        accept;
    logic        wr_pending;
    logic        wr_commit;    // last cycle of a write data phase.
    logic        enable;
    logic [31:0] count;
    logic [31:0] compare;

    assign accept = bus.hsel && bus.hready &&
                    ((bus.htrans == ahb_pkg::trans_nonseq) || (bus.htrans == ahb_pkg::trans_seq));
    assign wr_commit = wr_pending && bus.hready;

    always_ff @(posedge HCLK or negedge rst_n) begin
        if (!rst_n) begin
            reg_q      <= soc_map_pkg::timer_ctrl;
            wr_pending <= 1'b0;
            enable     <= 1'b0;
            count      <= 32'h0;
            compare    <= 32'h0;
            timer_irq  <= 1'b0;
        end else begin
            if (accept)
                reg_q <= soc_map_pkg::timer_reg_t'(bus.haddr[3:2]);
            if (bus.hready)
                wr_pending <= accept && bus.hwrite;
            if (wr_commit && reg_q == soc_map_pkg::timer_ctrl)
                enable <= bus.hwdata[0];
            if (wr_commit && reg_q == soc_map_pkg::timer_compare)
                compare <= bus.hwdata;
            if (wr_commit && reg_q == soc_map_pkg::timer_count)
                count <= bus.hwdata;   // load wins over increment.
            else if (enable)
                count <= count + 32'd1;
            if (wr_commit && reg_q == soc_map_pkg::timer_status)
                timer_irq <= 1'b0;     // any write clears.
            else if (enable && count == compare)
                timer_irq <= 1'b1;
        end
    end

    always_comb begin
        case (reg_q)
            soc_map_pkg::timer_ctrl:    bus.hrdata = {31'h0, enable};
            soc_map_pkg::timer_count:   bus.hrdata = count;
            soc_map_pkg::timer_compare: bus.hrdata = compare;
            default:                    bus.hrdata = {31'h0, timer_irq};
        endcase
    end

    assign bus.hreadyout = 1'b1;
    assign bus.hresp     = ahb_pkg::resp_okay;

endmodule

// File: hdl/soc_consts.svh
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// word-address bits of the RAM.
`define SOC_RAM_ADDR_WIDTH 10

// RAM window, matched on haddr[28].
`define SOC_RAM_MATCH 1'b0

// peripheral windows, matched on haddr[28:22].
`define SOC_GPIO_MATCH 7'h7e
`define SOC_TIMER_MATCH 7'h7d

// board pins.
`define SOC_SWITCH_WIDTH 18
`define SOC_BUTTON_WIDTH 5
`define SOC_RED_WIDTH 18
`define SOC_GREEN_WIDTH 9

`endif

// File: hdl/soc_map_pkg.sv
package soc_map_pkg;

    typedef enum logic [1:0] {
        sel_ram,
        sel_gpio,
        sel_timer,
        sel_none     // unmapped, goes to the error slave.
    } slave_sel_t;

    // word offsets inside the GPIO window.
    typedef enum logic [1:0] {
        gpio_switches   = 2'd0,
        gpio_buttons    = 2'd1,
        gpio_red_leds   = 2'd2,
        gpio_green_leds = 2'd3
    } gpio_reg_t;

    // word offsets inside the timer window.
    typedef enum logic [1:0] {
        timer_ctrl    = 2'd0,
        timer_count   = 2'd1,
        timer_compare = 2'd2,
        timer_status  = 2'd3
    } timer_reg_t;

endpackage

// File: verification/tb_ahb_matrix.sv
`timescale 1ns/1ns
`include "soc_consts.svh"

module tb_ahb_matrix;

    localparam int          NUM_TESTS  = 6;
    localparam logic [31:0] GPIO_BASE  = 32'h1f80_0000;
    localparam logic [31:0] TIMER_BASE = 32'h1f40_0000;

    logic                         HCLK;
    logic                         rst_n;
    logic [31:0]                  haddr;
    ahb_pkg::htrans_t             htrans;
    logic                         hwrite;
    logic [31:0]                  hwdata;
    logic [31:0]                  hrdata;
    logic                         hready;
    ahb_pkg::hresp_t              hresp;
    logic [`SOC_SWITCH_WIDTH-1:0] io_switches;
    logic [`SOC_BUTTON_WIDTH-1:0] io_buttons;
    logic [`SOC_RED_WIDTH-1:0]    io_red_leds;
    logic [`SOC_GREEN_WIDTH-1:0]  io_green_leds;
    logic                         timer_irq;

    // transfer list and the results of its data phases, in issue order.
    logic [31:0]     op_addr[$];
    logic            op_write[$];
    logic [31:0]     op_wdata[$];
    logic [31:0]     res_rdata[$];
    ahb_pkg::hresp_t res_resp[$];
    int              res_cycles[$];
    logic [31:0]     ram_model[int];   // keyed by word address.

    int errors = 0;
    int tests = 0;
    int start_errors = 0;
    int first_draw;

    tb_clock_gen clock_gen (.HCLK(HCLK), .rst_n(rst_n));

    ahb_matrix dut (
        .HCLK          (HCLK),
        .rst_n         (rst_n),
        .haddr         (haddr),
        .htrans        (htrans),
        .hwrite        (hwrite),
        .hwdata        (hwdata),
        .hrdata        (hrdata),
        .hready        (hready),
        .hresp         (hresp),
        .io_switches   (io_switches),
        .io_buttons    (io_buttons),
        .io_red_leds   (io_red_leds),
        .io_green_leds (io_green_leds),
        .timer_irq     (timer_irq)
    );

    task automatic check_word(input string name, input logic [31:0] actual, input logic [31:0] exp);
        if (actual !== exp) begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, exp);
            errors++;
        end
    endtask

    task automatic check_resp(input string name, input ahb_pkg::hresp_t actual,
                              input ahb_pkg::hresp_t exp);
        if (actual !== exp) begin
            $display("CHECK FAILED at %0t ns: %s is %s, expected %s",
                     $time, name, actual.name(), exp.name());
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic exp);
        if (actual !== exp) begin
            $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, name, actual, exp);
            errors++;
        end
    endtask

    task automatic clear_ops();
        op_addr.delete();
        op_write.delete();
        op_wdata.delete();
    endtask

    task automatic add_op(input logic [31:0] addr, input logic write, input logic [31:0] wdata);
        op_addr.push_back(addr);
        op_write.push_back(write);
        op_wdata.push_back(wdata);
    endtask

    // issues the list back to back; starts and returns on a falling edge,
    // half a cycle after the edge that ends the last data phase.
    task automatic run_ops();
        int ai;
        int di;
        int cyc;
        ai = 0;
        di = -1;
        cyc = 0;
        res_rdata.delete();
        res_resp.delete();
        res_cycles.delete();
        forever begin
            if (ai < op_addr.size()) begin
                haddr  = op_addr[ai];
                hwrite = op_write[ai];
                htrans = ahb_pkg::trans_nonseq;
            end else begin
                htrans = ahb_pkg::trans_idle;
            end
            if (di >= 0) begin
                hwdata = op_wdata[di];
                cyc++;
            end
            if (hready) begin   // the coming edge ends a data phase.
                if (di >= 0) begin
                    res_rdata.push_back(hrdata);
                    res_resp.push_back(hresp);
                    res_cycles.push_back(cyc);
                end
                di = (ai < op_addr.size()) ? ai : -1;
                if (ai < op_addr.size())
                    ai++;
                cyc = 0;
                if (di < 0)
                    break;
            end
            @(negedge HCLK);
        end
        @(negedge HCLK);
    endtask

    // walks the list against the RAM model.
    task automatic check_ram_results();
        int key;
        for (int i = 0; i < op_addr.size(); i++) begin
            key = int'(op_addr[i][`SOC_RAM_ADDR_WIDTH+1:2]);
            check_resp("hresp", res_resp[i], ahb_pkg::resp_okay);
            if (op_write[i]) begin
                ram_model[key] = op_wdata[i];
                check_word("write data phase cycles", 32'(res_cycles[i]), 32'd1);
            end else begin
                check_word("hrdata", res_rdata[i], ram_model[key]);
                check_word("read data phase cycles", 32'(res_cycles[i]), 32'd2);
            end
        end
    endtask

    task automatic begin_test();
        start_errors = errors;
        tests++;
    endtask

    task automatic end_test(input string name);
        $display("test %-14s %s", name, (errors == start_errors) ? "passed" : "FAILED");
    endtask

    task automatic test_reset_state();
        begin_test();
        check_bit("hready", hready, 1'b1);
        check_resp("hresp", hresp, ahb_pkg::resp_okay);
        check_word("io_red_leds", 32'(io_red_leds), 32'h0);
        check_word("io_green_leds", 32'(io_green_leds), 32'h0);
        check_bit("timer_irq", timer_irq, 1'b0);
        end_test("reset_state");
    endtask

    task automatic test_ram_storage();
        logic [`SOC_RAM_ADDR_WIDTH-1:0] waddr [32];
        begin_test();
        clear_ops();
        for (int i = 0; i < 32; i++) begin
            waddr[i] = $urandom;
            add_op(32'(waddr[i]) << 2, 1'b1, $urandom);
        end
        run_ops();
        check_ram_results();
        clear_ops();
        for (int i = 0; i < 32; i++)
            add_op(32'(waddr[i]) << 2, 1'b0, 32'h0);
        run_ops();
        check_ram_results();
        end_test("ram_storage");
    endtask

    task automatic test_pipelined();
        begin_test();
        clear_ops();
        add_op(32'h0000_0040, 1'b1, $urandom);
        add_op(32'h0000_0044, 1'b1, $urandom);
        add_op(32'h0000_0044, 1'b0, 32'h0);   // read right behind its write.
        add_op(32'h0000_0040, 1'b0, 32'h0);
        add_op(32'h0000_0040, 1'b1, $urandom);
        add_op(32'h0000_0040, 1'b0, 32'h0);
        run_ops();
        check_ram_results();
        end_test("pipelined");
    endtask

    task automatic test_gpio();
        logic [31:0] led_word;
        begin_test();
        io_switches = $urandom;
        io_buttons  = $urandom;
        clear_ops();
        add_op(GPIO_BASE, 1'b0, 32'h0);
        add_op(GPIO_BASE + 32'h4, 1'b0, 32'h0);
        run_ops();
        check_word("switch read", res_rdata[0], 32'(io_switches));
        check_word("button read", res_rdata[1], 32'(io_buttons));
        led_word = $urandom;
        clear_ops();
        add_op(GPIO_BASE + 32'h8, 1'b1, led_word);
        run_ops();
        check_word("io_red_leds", 32'(io_red_leds), 32'(led_word[`SOC_RED_WIDTH-1:0]));
        led_word = $urandom;
        clear_ops();
        add_op(GPIO_BASE + 32'hc, 1'b1, led_word);
        run_ops();
        check_word("io_green_leds", 32'(io_green_leds), 32'(led_word[`SOC_GREEN_WIDTH-1:0]));
        end_test("gpio");
    endtask

    task automatic test_timer();
        logic [31:0] count_val;
        begin_test();
        clear_ops();
        add_op(TIMER_BASE + 32'h8, 1'b1, 32'd200);
        add_op(TIMER_BASE, 1'b1, 32'h1);
        run_ops();
        repeat (50) @(negedge HCLK);
        check_bit("timer_irq", timer_irq, 1'b0);
        clear_ops();
        add_op(TIMER_BASE + 32'h4, 1'b0, 32'h0);
        run_ops();
        count_val = res_rdata[0];
        if (count_val < 32'd1 || count_val > 32'd200) begin
            $display("at %0t ns the count read %0d lies outside 1 to 200", $time, count_val);
            errors++;
        end
        repeat (300) @(negedge HCLK);
        check_bit("timer_irq", timer_irq, 1'b1);
        clear_ops();
        add_op(TIMER_BASE + 32'hc, 1'b1, 32'h0);
        run_ops();
        check_bit("timer_irq", timer_irq, 1'b0);
        end_test("timer");
    endtask

    task automatic test_unmapped();
        begin_test();
        haddr  = 32'h1000_0000;
        hwrite = 1'b0;
        htrans = ahb_pkg::trans_nonseq;
        while (!hready)
            @(negedge HCLK);
        @(negedge HCLK);
        htrans = ahb_pkg::trans_idle;
        check_bit("hready in first error cycle", hready, 1'b0);
        check_resp("hresp in first error cycle", hresp, ahb_pkg::resp_error);
        @(negedge HCLK);
        check_bit("hready in second error cycle", hready, 1'b1);
        check_resp("hresp in second error cycle", hresp, ahb_pkg::resp_error);
        @(negedge HCLK);
        clear_ops();
        add_op(32'h0000_0100, 1'b1, $urandom);
        add_op(32'h0000_0100, 1'b0, 32'h0);
        run_ops();
        check_ram_results();
        end_test("unmapped");
    endtask

    // bounds the run by the test count.
    initial begin
        repeat (NUM_TESTS * 2000) @(posedge HCLK);
        $display("timeout: the tests did not finish within %0d cycles", NUM_TESTS * 2000);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        first_draw  = $urandom(32'h14dc_7c17);
        haddr       = 32'h0;
        htrans      = ahb_pkg::trans_idle;
        hwrite      = 1'b0;
        hwdata      = 32'h0;
        io_switches = '0;
        io_buttons  = '0;
        wait (rst_n === 1'b1);
        @(negedge HCLK);
        test_reset_state();
        test_ram_storage();
        test_pipelined();
        test_gpio();
        test_timer();
        test_unmapped();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 10
) (
    output logic HCLK,
    output logic rst_n
);

    initial begin
        HCLK = 1'b0;
        forever #HALF_PERIOD HCLK = ~HCLK;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge HCLK);
        @(negedge HCLK);
        rst_n = 1'b1;   // released away from the active edge.
    end

endmodule
